/* dist_pkg.sv */
package dist_pkg;

    //////////////////////////////
    // Pool sizes
    //////////////////////////////
    localparam int NUM_JOB_TYPES = 4;
    localparam int NUM_FTHREADS  = 4;
    localparam int JOB_TY_W      = 2;

    // Word and field widths
    localparam int JOB_W      = 128;
    localparam int OPCODE_W   = 16;
    localparam int ADDR_W     = 58;
    localparam int OFFSET_W   = 32;
    localparam int CMD_W      = 8;
    localparam int PARAM_W    = 16;
    // Command byte, read address, write address, parameter
    localparam int CMD_LINE_W = CMD_W + ADDR_W + ADDR_W + PARAM_W;

    //////////////////////////////
    // Job word layout
    //////////////////////////////
    localparam int JOB_CMD_LSB    = 0;
    localparam int JOB_PARAM_LSB  = 8;
    // Bits 31..24 are unused
    localparam int JOB_RD_OFS_LSB = 32;
    localparam int JOB_WR_OFS_LSB = 64;

    //////////////////////////////
    // Distributor FSM states
    //////////////////////////////
    localparam logic [1:0] DIST_READY    = 2'b00;
    localparam logic [1:0] DIST_SCHEDULE = 2'b01;
    localparam logic [1:0] DIST_SUCCESS  = 2'b10;
    localparam logic [1:0] DIST_FAIL     = 2'b11;

endpackage

/* job_type_rotator.sv */
module job_type_rotator (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          advance,
    output logic [dist_pkg::JOB_TY_W-1:0] cur_type
);
    import dist_pkg::*;

    // Last queue index where the pointer wraps
    localparam logic [JOB_TY_W-1:0] LAST_TYPE = JOB_TY_W'(NUM_JOB_TYPES - 1);

    //////////////////////////////
    // Round-robin pointer
    //////////////////////////////
    // Moves only while the FSM sits in READY,
    // so a job that cannot be placed does not starve the other queues
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_type <= '0;
        end else if (advance) begin
            if (cur_type == LAST_TYPE) begin
                cur_type <= '0;
            end else begin
                cur_type <= cur_type + 1'b1;
            end
        end
    end

endmodule

/* dist_fsm.sv */
module dist_fsm (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [dist_pkg::JOB_TY_W-1:0]      cur_type,
    input  logic [dist_pkg::NUM_JOB_TYPES-1:0] job_queue_valid,
    input  logic [dist_pkg::JOB_W-1:0]         job_queue_data [dist_pkg::NUM_JOB_TYPES],
    input  logic                               decision_made,
    input  logic                               success,
    output logic                               advance,
    output logic [dist_pkg::JOB_W-1:0]         job_request,
    output logic [dist_pkg::JOB_TY_W-1:0]      job_index,
    output logic                               req_valid,
    output logic [dist_pkg::NUM_JOB_TYPES-1:0] job_queue_ready
);
    import dist_pkg::*;

    logic [1:0] state;
    logic       take_job;

    // Queue under the pointer has a job and nothing is in flight
    assign take_job = (state == DIST_READY) && job_queue_valid[cur_type];
    assign advance  = (state == DIST_READY);

    //////////////////////////////
    // State register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= DIST_READY;
            req_valid <= 1'b0;
        end else begin
            // Request lasts only the first SCHEDULE cycle
            req_valid <= take_job;
            case (state)
                DIST_READY: begin
                    if (take_job) begin
                        state <= DIST_SCHEDULE;
                    end
                end
                DIST_SCHEDULE: begin
                    // Tracker answers in the second SCHEDULE cycle
                    if (decision_made) begin
                        state <= success ? DIST_SUCCESS : DIST_FAIL;
                    end
                end
                default: state <= DIST_READY;
            endcase
        end
    end

    // Job word and its queue index held through the decision
    always_ff @(posedge clk) begin
        if (take_job) begin
            job_request <= job_queue_data[cur_type];
            job_index   <= cur_type;
        end
    end

    // Acknowledge only the captured queue and only on a placed job
    always_comb begin
        job_queue_ready = '0;
        job_queue_ready[job_index] = (state == DIST_SCHEDULE) && decision_made && success;
    end

    // Tracker decides exactly one cycle after the request
    a_decision_follows_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid |=> decision_made
    );

    // Acknowledged queue still holds the captured job
    a_ready_queue_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        |job_queue_ready |-> job_queue_valid[job_index]
    );

endmodule

/* opcode_matrix.sv */
module opcode_matrix (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [dist_pkg::OPCODE_W-1:0]     fthread_config [dist_pkg::NUM_FTHREADS],
    input  logic                              fthread_config_valid,
    input  logic [dist_pkg::OPCODE_W-1:0]     job_config [dist_pkg::NUM_JOB_TYPES],
    input  logic                              job_config_valid,
    output logic [dist_pkg::NUM_FTHREADS-1:0] mapping [dist_pkg::NUM_JOB_TYPES]
);
    import dist_pkg::*;

    logic [OPCODE_W-1:0] fthread_opcode [NUM_FTHREADS];
    logic [OPCODE_W-1:0] job_opcode [NUM_JOB_TYPES];
    logic                fthread_loaded;
    logic                job_loaded;

    //////////////////////////////
    // Opcode tables
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (fthread_config_valid) begin
            fthread_opcode <= fthread_config;
        end
        if (job_config_valid) begin
            job_opcode <= job_config;
        end
    end

    // Loaded flags, set once per table
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fthread_loaded <= 1'b0;
            job_loaded     <= 1'b0;
        end else begin
            fthread_loaded <= fthread_loaded | fthread_config_valid;
            job_loaded     <= job_loaded | job_config_valid;
        end
    end

    //////////////////////////////
    // Mapping matrix
    //////////////////////////////
    // Row t marks every fthread able to run job type t
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mapping <= '{default: '0};
        end else if (fthread_loaded && job_loaded) begin
            for (int t = 0; t < NUM_JOB_TYPES; t++) begin
                for (int f = 0; f < NUM_FTHREADS; f++) begin
                    mapping[t][f] <= (job_opcode[t] == fthread_opcode[f]);
                end
            end
        end
    end

endmodule

/* fthread_tracker.sv */
module fthread_tracker (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [dist_pkg::NUM_FTHREADS-1:0] mapping [dist_pkg::NUM_JOB_TYPES],
    input  logic [dist_pkg::JOB_TY_W-1:0]     job_index,
    input  logic                              req_valid,
    input  logic [dist_pkg::NUM_FTHREADS-1:0] fthread_done,
    output logic                              decision_made,
    output logic                              success,
    output logic [dist_pkg::NUM_FTHREADS-1:0] job_set
);
    import dist_pkg::*;

    localparam logic [NUM_FTHREADS-1:0] ONE = NUM_FTHREADS'(1);

    logic [NUM_FTHREADS-1:0] avail;
    logic [NUM_FTHREADS-1:0] pick;
    logic [NUM_FTHREADS-1:0] pick_q;
    logic [NUM_FTHREADS-1:0] busy;

    //////////////////////////////
    // Free-fthread select
    //////////////////////////////
    // Matching fthreads that are idle
    assign avail = mapping[job_index] & ~busy;
    // Isolate lowest set bit so the lower index wins
    assign pick  = avail & (~avail + ONE);

    // Decision stage one cycle behind the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pick_q        <= '0;
            decision_made <= 1'b0;
        end else begin
            pick_q        <= pick;
            decision_made <= req_valid;
        end
    end

    assign success = |pick_q;
    assign job_set = decision_made ? pick_q : '0;

    //////////////////////////////
    // Busy state
    //////////////////////////////
    // A new job wins over a done pulse in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= job_set | (busy & ~fthread_done);
        end
    end

    // Done pulses come only from running fthreads
    a_done_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fthread_done & ~busy) == '0
    );

    a_job_set_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (job_set & busy) == '0
    );

endmodule

/* job_line_builder.sv */
module job_line_builder (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [dist_pkg::ADDR_W-1:0]       ws_base_addr,
    input  logic                              ws_base_addr_valid,
    input  logic [dist_pkg::JOB_W-1:0]        job_request,
    input  logic [dist_pkg::NUM_FTHREADS-1:0] job_set,
    output logic [dist_pkg::CMD_LINE_W-1:0]   fthread_job [dist_pkg::NUM_FTHREADS],
    output logic [dist_pkg::NUM_FTHREADS-1:0] fthread_job_valid
);
    import dist_pkg::*;

    logic [ADDR_W-1:0]     base_q;
    logic [ADDR_W-1:0]     rd_addr;
    logic [ADDR_W-1:0]     wr_addr;
    logic [OFFSET_W-1:0]   rd_ofs;
    logic [OFFSET_W-1:0]   wr_ofs;
    logic [CMD_LINE_W-1:0] job_line;

    // Workspace base, written once by software
    always_ff @(posedge clk) begin
        if (ws_base_addr_valid) begin
            base_q <= ws_base_addr;
        end
    end

    //////////////////////////////
    // Address adders
    //////////////////////////////
    assign rd_ofs = job_request[JOB_RD_OFS_LSB +: OFFSET_W];
    assign wr_ofs = job_request[JOB_WR_OFS_LSB +: OFFSET_W];

    // Ready one cycle after capture, ahead of the decision cycle
    always_ff @(posedge clk) begin
        rd_addr <= base_q + ADDR_W'(rd_ofs);
        wr_addr <= base_q + ADDR_W'(wr_ofs);
    end

    // Command byte on top, parameter at the bottom
    assign job_line = {job_request[JOB_CMD_LSB +: CMD_W], rd_addr, wr_addr,
                       job_request[JOB_PARAM_LSB +: PARAM_W]};

    //////////////////////////////
    // Per-fthread outputs
    //////////////////////////////
    always_ff @(posedge clk) begin
        for (int f = 0; f < NUM_FTHREADS; f++) begin
            if (job_set[f]) begin
                fthread_job[f] <= job_line;
            end
        end
    end

    // One-cycle valid pulse follows job_set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fthread_job_valid <= '0;
        end else begin
            fthread_job_valid <= job_set;
        end
    end

endmodule

/* job_distributor.sv */
module job_distributor (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [dist_pkg::OPCODE_W-1:0]      fthread_config [dist_pkg::NUM_FTHREADS],
    input  logic                               fthread_config_valid,
    input  logic [dist_pkg::OPCODE_W-1:0]      job_config [dist_pkg::NUM_JOB_TYPES],
    input  logic                               job_config_valid,
    input  logic [dist_pkg::NUM_JOB_TYPES-1:0] job_queue_valid,
    input  logic [dist_pkg::JOB_W-1:0]         job_queue_data [dist_pkg::NUM_JOB_TYPES],
    output logic [dist_pkg::NUM_JOB_TYPES-1:0] job_queue_ready,
    input  logic [dist_pkg::ADDR_W-1:0]        ws_base_addr,
    input  logic                               ws_base_addr_valid,
    output logic [dist_pkg::CMD_LINE_W-1:0]    fthread_job [dist_pkg::NUM_FTHREADS],
    output logic [dist_pkg::NUM_FTHREADS-1:0]  fthread_job_valid,
    input  logic [dist_pkg::NUM_FTHREADS-1:0]  fthread_done
);
    import dist_pkg::*;

    // Pointer and captured job
    logic [JOB_TY_W-1:0]     cur_type;
    logic                    advance;
    logic [JOB_W-1:0]        job_request;
    logic [JOB_TY_W-1:0]     job_index;
    logic                    req_valid;
    // Decision path
    logic [NUM_FTHREADS-1:0] mapping [NUM_JOB_TYPES];
    logic                    decision_made;
    logic                    success;
    logic [NUM_FTHREADS-1:0] job_set;

    job_type_rotator job_type_rotator_inst (
        .clk, .rst_n, .advance, .cur_type
    );

    dist_fsm dist_fsm_inst (
        .clk, .rst_n, .cur_type, .job_queue_valid, .job_queue_data,
        .decision_made, .success, .advance, .job_request, .job_index,
        .req_valid, .job_queue_ready
    );

    opcode_matrix opcode_matrix_inst (
        .clk, .rst_n, .fthread_config, .fthread_config_valid,
        .job_config, .job_config_valid, .mapping
    );

    fthread_tracker fthread_tracker_inst (
        .clk, .rst_n, .mapping, .job_index, .req_valid, .fthread_done,
        .decision_made, .success, .job_set
    );

    job_line_builder job_line_builder_inst (
        .clk, .rst_n, .ws_base_addr, .ws_base_addr_valid, .job_request,
        .job_set, .fthread_job, .fthread_job_valid
    );

endmodule

/* tb_job_distributor.sv */
module tb_job_distributor;
    timeunit 1ns;
    timeprecision 1ps;
    import dist_pkg::*;

    // Word index of the first job row in the vector memory
    localparam int FIRST_JOB    = 10;
    // Cycles a blocked job is watched before its done pulse
    localparam int STALL_CYCLES = 24;

    logic                     clk;
    logic                     rst_n;
    logic [OPCODE_W-1:0]      fthread_config [NUM_FTHREADS];
    logic                     fthread_config_valid;
    logic [OPCODE_W-1:0]      job_config [NUM_JOB_TYPES];
    logic                     job_config_valid;
    logic [NUM_JOB_TYPES-1:0] job_queue_valid;
    logic [JOB_W-1:0]         job_queue_data [NUM_JOB_TYPES];
    logic [NUM_JOB_TYPES-1:0] job_queue_ready;
    logic [ADDR_W-1:0]        ws_base_addr;
    logic                     ws_base_addr_valid;
    logic [CMD_LINE_W-1:0]    fthread_job [NUM_FTHREADS];
    logic [NUM_FTHREADS-1:0]  fthread_job_valid;
    logic [NUM_FTHREADS-1:0]  fthread_done;

    // Config words first, then 4 words per job row
    logic [JOB_W-1:0]         vec [0:63];
    int                       num_jobs;
    // Reference model of the pool
    logic [NUM_FTHREADS-1:0]  model_map [NUM_JOB_TYPES];
    logic [NUM_FTHREADS-1:0]  model_busy;
    logic [ADDR_W-1:0]        model_base;

    job_distributor job_distributor_inst (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////
    task automatic check_value(input string name, input logic [CMD_LINE_W-1:0] actual,
                               input logic [CMD_LINE_W-1:0] expected);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%0h got 0x%0h", name, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Command byte, base plus read offset, base plus write offset, parameter
    function automatic logic [CMD_LINE_W-1:0] expected_line(input logic [JOB_W-1:0] job);
        logic [ADDR_W-1:0] rd_addr;
        logic [ADDR_W-1:0] wr_addr;
        rd_addr = model_base + ADDR_W'(job[JOB_RD_OFS_LSB +: OFFSET_W]);
        wr_addr = model_base + ADDR_W'(job[JOB_WR_OFS_LSB +: OFFSET_W]);
        return {job[JOB_CMD_LSB +: CMD_W], rd_addr, wr_addr, job[JOB_PARAM_LSB +: PARAM_W]};
    endfunction

    // Lowest free fthread with a matching opcode or -1 if none
    function automatic int pick_fthread(input logic [JOB_TY_W-1:0] t);
        for (int f = 0; f < NUM_FTHREADS; f++) begin
            if (model_map[t][f] && !model_busy[f]) begin
                return f;
            end
        end
        return -1;
    endfunction

    // No acknowledge and no command line for a number of cycles
    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("job_queue_ready", CMD_LINE_W'(job_queue_ready), '0);
            check_value("fthread_job_valid", CMD_LINE_W'(fthread_job_valid), '0);
        end
    endtask

    task automatic pulse_done(input logic [NUM_FTHREADS-1:0] mask);
        @(posedge clk);
        fthread_done <= mask;
        @(posedge clk);
        fthread_done <= '0;
        model_busy = model_busy & ~mask;
    endtask

    task automatic present_job(input int q, input logic [JOB_W-1:0] job);
        @(posedge clk);
        job_queue_data[q]  <= job;
        job_queue_valid[q] <= 1'b1;
    endtask

    // Ready pulse on queue q, then the command line on fthread f one cycle later
    task automatic await_job(input int q, input int f, input logic [JOB_W-1:0] job);
        @(negedge clk);
        while (job_queue_ready == '0) begin
            check_value("fthread_job_valid", CMD_LINE_W'(fthread_job_valid), '0);
            @(negedge clk);
        end
        check_value("job_queue_ready", CMD_LINE_W'(job_queue_ready), CMD_LINE_W'(1) << q);
        @(posedge clk);
        job_queue_valid[q] <= 1'b0;
        @(negedge clk);
        // Ready lasts a single cycle
        check_value("job_queue_ready", CMD_LINE_W'(job_queue_ready), '0);
        check_value("fthread_job_valid", CMD_LINE_W'(fthread_job_valid), CMD_LINE_W'(1) << f);
        check_value($sformatf("fthread_job[%0d]", f), fthread_job[f], expected_line(job));
        model_busy[f] = 1'b1;
        // Valid is a single-cycle pulse
        @(negedge clk);
        check_value("fthread_job_valid", CMD_LINE_W'(fthread_job_valid), '0);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int                      q;
        int                      exp_f;
        int                      model_f;
        logic [NUM_FTHREADS-1:0] done_mask;
        logic [JOB_W-1:0]        job;
        $readmemh("dist_input.txt", vec);
        num_jobs              = int'(vec[9][15:0]);
        rst_n                <= 1'b0;
        fthread_config       <= '{default: '0};
        fthread_config_valid <= 1'b0;
        job_config           <= '{default: '0};
        job_config_valid     <= 1'b0;
        job_queue_valid      <= '0;
        job_queue_data       <= '{default: '0};
        ws_base_addr         <= '0;
        ws_base_addr_valid   <= 1'b0;
        fthread_done         <= '0;
        model_busy            = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        // Idle outputs before any configuration
        expect_quiet(4);

        // Opcode tables and workspace base in one strobe cycle
        @(posedge clk);
        for (int f = 0; f < NUM_FTHREADS; f++) begin
            fthread_config[f] <= vec[f][OPCODE_W-1:0];
        end
        for (int t = 0; t < NUM_JOB_TYPES; t++) begin
            job_config[t] <= vec[4 + t][OPCODE_W-1:0];
        end
        ws_base_addr         <= vec[8][ADDR_W-1:0];
        fthread_config_valid <= 1'b1;
        job_config_valid     <= 1'b1;
        ws_base_addr_valid   <= 1'b1;
        @(posedge clk);
        fthread_config_valid <= 1'b0;
        job_config_valid     <= 1'b0;
        ws_base_addr_valid   <= 1'b0;
        model_base = vec[8][ADDR_W-1:0];
        for (int t = 0; t < NUM_JOB_TYPES; t++) begin
            for (int f = 0; f < NUM_FTHREADS; f++) begin
                model_map[t][f] = (vec[4 + t][OPCODE_W-1:0] == vec[f][OPCODE_W-1:0]);
            end
        end
        expect_quiet(4);

        for (int r = 0; r < num_jobs; r++) begin
            q         = int'(vec[FIRST_JOB + 4 * r][JOB_TY_W-1:0]);
            exp_f     = int'(vec[FIRST_JOB + 4 * r + 1][3:0]);
            done_mask = vec[FIRST_JOB + 4 * r + 2][NUM_FTHREADS-1:0];
            job       = vec[FIRST_JOB + 4 * r + 3];
            model_f   = pick_fthread(JOB_TY_W'(q));
            // Nothing free for this type so the job must wait unacknowledged
            if (model_f < 0) begin
                present_job(q, job);
                expect_quiet(STALL_CYCLES);
            end
            if (done_mask != '0) begin
                pulse_done(done_mask);
            end
            model_f = pick_fthread(JOB_TY_W'(q));
            if (!job_queue_valid[q]) begin
                present_job(q, job);
            end
            check_value("fthread index column", CMD_LINE_W'(exp_f),
                        CMD_LINE_W'(model_f < 0 ? 15 : model_f));
            // Unplaceable jobs stay parked in their queue
            if (model_f >= 0) begin
                await_job(q, model_f, job);
            end
        end
        expect_quiet(8);
        $display("test passed");
        $finish;
    end

    // Watchdog allows 40 cycles per job row plus margin for reset and setup
    initial begin
        int limit;
        #1;
        limit = 40 * num_jobs + 100;
        repeat (limit) @(posedge clk);
        $display("Run timed out after %0d cycles before all job rows were served", limit);
        $display("test failed");
        $fatal(1, "timeout");
    end

endmodule

/* dist_input.txt */
// Words 0-3 fthread opcodes, 4-7 job type opcodes, 8 workspace base, 9 job row count
// Job rows: queue, expected fthread (f = none), done mask, job word
00a1 00a1 00b2 00c3
00a1 00b2 00d4 00c3
123456789abc000 8
0 0 0 000000000000200000001000000a0111
1 2 0 000000000000c000ffff000000b20222
0 1 0 00000000000140000001000000a10333
2 f 0 00000000000000400000002000d40444
3 3 0 00000000fffffff00000010000c30555
0 1 2 00000000003000000020000000a10666
1 2 4 00000000800000007fffffff00b20777
0 0 3 00000000000000080000000400a10888

/* project.f */
dist_pkg.sv
job_type_rotator.sv
dist_fsm.sv
opcode_matrix.sv
fthread_tracker.sv
job_line_builder.sv
job_distributor.sv
tb_job_distributor.sv

/* Makefile */
TOP = tb_job_distributor

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir
